// ==== Makefile ====
SIM := obj_dir/sgb_bus_sim

all: run

$(SIM): flist.f sgb_macros.svh $(shell grep '\.sv$$' flist.f)
	verilator --binary --assert -f flist.f --top-module sgb_bus_tb -o sgb_bus_sim

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '^PASS: all tests$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== address.sv ====
`timescale 1ns/1ps
`include "sgb_macros.svh"

module address (
  input  sgb_pkg::snes_bus_t      snes,
  input  logic [`SGB_FEAT_W-1:0]  featurebits,
  output sgb_pkg::addr_decode_t   decode
);

  ////////////////////////////////////////////////////////////////////////////
  // ROM side
  ////////////////////////////////////////////////////////////////////////////

  logic is_rom;

  // Upper half of banks $00-$3F or anything from $40 up is ROM
  assign is_rom = snes.addr[22] | snes.addr[15];

  always_comb begin
    // LoROM only, 512 KB max
    // Bank nibble sits right above the 32 KB offset
    decode.rom_addr = {5'h00, snes.addr[19:16], snes.addr[14:0]};
    decode.is_rom   = is_rom;
    // No save RAM here, so a hit is a ROM hit
    decode.rom_hit  = is_rom;

    //////////////////////////////////////////////////////////////////////////
    // Peripheral windows
    //////////////////////////////////////////////////////////////////////////

    // MSU-1 at $2000-$2007 in system banks only
    decode.msu_enable = featurebits[`SGB_FEAT_MSU1] & ~snes.addr[22] &
                        (snes.addr[15:3] == 13'h0400);

    // SGB registers
    // $6000-$6003 style and $600F style plus the whole $7xxx page
    decode.sgb_enable = ~snes.addr[22] &
                        (((snes.addr[15:0] & 16'hf80c) == 16'h6000) |
                         ((snes.addr[15:0] & 16'hf80f) == 16'h600f) |
                         (snes.addr[15:12] == 4'h7));

    // B-bus registers
    decode.r213f_enable = featurebits[`SGB_FEAT_213F] & (snes.pa == 8'h3f);
    // Always decoded
    decode.r2100_hit    = (snes.pa == 8'h00);

    // snescmd area $2A00-$2BFF
    decode.snescmd_enable = ~snes.addr[22] & (snes.addr[15:9] == 7'b0010101);

    // Hook code stores the joypad bytes at $010F11 and $010F12
    decode.button_enable = ({snes.addr[23:2], 2'b00} == 24'h010f10) &
                           (snes.addr[1] ^ snes.addr[0]);
    decode.button_addr   = ~snes.addr[0];
  end

  // Buffer and snoop must never claim the same write
  always_comb begin
    assert (!(decode.button_enable && decode.snescmd_enable))
      else $error("button and snescmd windows overlap");
  end

endmodule

// ==== button_snoop.sv ====
`timescale 1ns/1ps
`include "sgb_macros.svh"

module button_snoop (
  input  logic                  clk,
  input  logic                  reset,
  input  sgb_pkg::snes_bus_t    snes,
  input  sgb_pkg::addr_decode_t decode,
  output logic [15:0]           buttons
);

  logic btn_wr;

  // Write strobe plus this cycle's decode
  assign btn_wr = snes.wr & decode.button_enable;

  ////////////////////////////////////////////////////////////////////////////
  // Joypad capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      buttons <= '0;
    end else if (btn_wr) begin
      if (decode.button_addr) begin
        // $010F12
        buttons[15:8] <= snes.data;
      end else begin
        // $010F11
        buttons[7:0] <= snes.data;
      end
    end
  end

  // Any change traces back to a decoded button write
  a_btn_quiet: assert property (
    @(posedge clk) disable iff (reset)
    !btn_wr |=> $stable(buttons)
  ) else $error("buttons changed without a snooped write");

endmodule

// ==== feature_regs.sv ====
`timescale 1ns/1ps
`include "sgb_macros.svh"

module feature_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   feat_wr,
  input  logic [`SGB_FEAT_W-1:0] feat_data,
  output logic [`SGB_FEAT_W-1:0] featurebits
);

  ////////////////////////////////////////////////////////////////////////////
  // MCU configuration word
  ////////////////////////////////////////////////////////////////////////////

  // All optional windows off out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      featurebits <= '0;
    end else if (feat_wr) begin
      // New gating takes effect next cycle
      featurebits <= feat_data;
    end
  end

  // Only the MCU strobe may move the word
  a_feat_hold: assert property (
    @(posedge clk) disable iff (reset)
    !feat_wr |=> $stable(featurebits)
  ) else $error("featurebits changed without feat_wr");

endmodule

// ==== flist.f ====
+incdir+.
sgb_pkg.sv
address.sv
feature_regs.sv
button_snoop.sv
snescmd_ram.sv
sgb_bus_top.sv
sgb_bus_checker.sv
sgb_bus_tb.sv

// ==== sgb_bus_cases.txt ====
# op addr pa data exp_a exp_b, all hex; F,D: exp_a rom_addr, exp_b decode flags
# flags hit,rom,msu,sgb,213f,2100,cmd,btn,btn_hi; W: exp_a buttons; R,M: byte; 100 random
D 008000 ff 0000 000000 180
D 05ffff 12 0000 02ffff 180
D 401234 ff 0000 001234 180
D 002000 3f 0000 002000 000
D 002000 00 0000 002000 008
F 002000 3f 0018 002000 050
D 002007 00 0000 002007 048
D 006002 ff 0000 006002 020
D 00600f ff 0000 00600f 020
D 006008 ff 0000 006008 000
D 007abc ff 0000 007abc 020
D 407000 ff 0000 007000 180
D 002a00 ff 0000 002a00 004
D 002c00 ff 0000 002c00 000
W 010f11 ff 00a5 0000a5 000
W 010f12 ff 003c 003ca5 000
W 010f10 ff 0077 003ca5 000
W 010f13 ff 0077 003ca5 000
W 002a05 ff 0100 003ca5 000
W 002bfe ff 0100 003ca5 000
R 002a05 ff 0000 000100 000
M 0001fe ff 0000 000100 000

// ==== sgb_bus_checker.sv ====
`timescale 1ns/1ps
`include "sgb_macros.svh"

module sgb_bus_checker (
  input  logic                   clk,
  input  logic                   reset,
  input  sgb_pkg::addr_decode_t  decode,
  input  logic [15:0]            buttons,
  input  logic [`SGB_DATA_W-1:0] snes_rdata,
  input  logic                   snes_rvalid,
  input  logic [`SGB_DATA_W-1:0] mcu_rdata,
  input  logic                   mcu_rvalid,
  input  logic                   chk_valid,
  input  logic [7:0]             chk_op,
  input  logic [23:0]            chk_exp_a,
  input  logic [8:0]             chk_exp_b,
  output int                     err_count
);

  logic [8:0] flags;
  logic [8:0] mask;
  int         errors = 0;

  assign err_count = errors;

  // Same bit order as the cases file
  assign flags = {decode.rom_hit, decode.is_rom, decode.msu_enable, decode.sgb_enable,
                  decode.r213f_enable, decode.r2100_hit, decode.snescmd_enable,
                  decode.button_enable, decode.button_addr};
  // button_addr only means something inside the button pair
  assign mask = chk_exp_b[1] ? 9'h1ff : 9'h1fe;

  task automatic compare(input string name, input logic [23:0] expected,
                         input logic [23:0] actual);
    if (actual !== expected) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Mid-cycle compare, away from the driving edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!reset) begin
      // Valid pulses only in the check cycle of their own read
      compare("snes_rvalid", 24'(chk_valid && chk_op == "R"), 24'(snes_rvalid));
      compare("mcu_rvalid", 24'(chk_valid && chk_op == "M"), 24'(mcu_rvalid));
      if (chk_valid) begin
        case (chk_op)
          "F", "D": begin
            compare("rom_addr", chk_exp_a, decode.rom_addr);
            compare("decode flags", 24'(chk_exp_b & mask), 24'(flags & mask));
          end
          "W": compare("buttons", chk_exp_a, 24'(buttons));
          "R": compare("snes_rdata", chk_exp_a, 24'(snes_rdata));
          "M": compare("mcu_rdata", chk_exp_a, 24'(mcu_rdata));
          default: begin
            $display("unknown opcode %c in the cases file", chk_op);
            errors++;
          end
        endcase
      end
    end
  end

endmodule

// ==== sgb_bus_tb.sv ====
`timescale 1ns/1ps
`include "sgb_macros.svh"

module sgb_bus_tb;

  // One line of the cases file
  typedef struct packed {
    logic [7:0]  op;
    logic [23:0] addr;
    logic [7:0]  pa;
    logic [15:0] data;
    logic [23:0] exp_a;
    logic [8:0]  exp_b;
  } case_t;

  logic                   clk;
  logic                   reset;
  sgb_pkg::snes_bus_t     snes;
  sgb_pkg::mcu_port_t     mcu;
  sgb_pkg::addr_decode_t  decode;
  logic [15:0]            buttons;
  logic [`SGB_DATA_W-1:0] snes_rdata;
  logic                   snes_rvalid;
  logic [`SGB_DATA_W-1:0] mcu_rdata;
  logic                   mcu_rvalid;
  // Case under check, valid for the check cycle
  logic                   chk_valid;
  case_t                  chk_case;
  int                     err_count;
  case_t                  cases [$];
  // Bytes the SNES stored in the buffer so far
  logic [7:0]             shadow [0:511];
  integer                 seed = 32'haf8b64c1;
  int                     cycles = 0;
  int                     limit = 0;

  sgb_bus_top sgb_bus_top_i (
    .clk         (clk),
    .reset       (reset),
    .snes        (snes),
    .mcu         (mcu),
    .decode      (decode),
    .buttons     (buttons),
    .snes_rdata  (snes_rdata),
    .snes_rvalid (snes_rvalid),
    .mcu_rdata   (mcu_rdata),
    .mcu_rvalid  (mcu_rvalid)
  );

  sgb_bus_checker checker_i (
    .clk         (clk),
    .reset       (reset),
    .decode      (decode),
    .buttons     (buttons),
    .snes_rdata  (snes_rdata),
    .snes_rvalid (snes_rvalid),
    .mcu_rdata   (mcu_rdata),
    .mcu_rvalid  (mcu_rvalid),
    .chk_valid   (chk_valid),
    .chk_op      (chk_case.op),
    .chk_exp_a   (chk_case.exp_a),
    .chk_exp_b   (chk_case.exp_b),
    .err_count   (err_count)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Limit only armed once the case count is known
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: run passed %0d cycles without finishing", limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Cases file
  ////////////////////////////////////////////////////////////////////////////

  // Comment lines start with #
  task automatic load_cases(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [23:0] addr;
    logic [7:0]  pa;
    logic [15:0] data;
    logic [23:0] ea;
    logic [8:0]  eb;
    fd = $fopen("sgb_bus_cases.txt", "r");
    ok = (fd != 0);
    while (ok && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%c %h %h %h %h %h", op, addr, pa, data, ea, eb);
        if (n == 6) begin
          cases.push_back({op, addr, pa, data, ea, eb});
        end
      end
    end
    if (ok) begin
      $fclose(fd);
    end
    ok = ok && (cases.size() > 0);
  endtask

  // Strobe cycle, then a check cycle with the strobes low
  task automatic apply_case(input case_t c);
    case_t       t;
    logic [31:0] rnd;
    t = c;
    // Data 100 asks for a random byte
    if (t.op == "W" && t.data == 16'h0100) begin
      rnd = $random(seed);
      t.data = {8'h00, rnd[7:0]};
      shadow[t.addr[8:0]] = rnd[7:0];
    end
    // Expected 100 means the last byte written there
    if ((t.op == "R" || t.op == "M") && t.exp_a == 24'h000100) begin
      t.exp_a = {16'h0000, shadow[t.addr[8:0]]};
    end
    @(posedge clk);
    snes.addr     <= t.addr;
    snes.pa       <= t.pa;
    snes.data     <= t.data[7:0];
    snes.wr       <= (t.op == "W");
    snes.rd       <= (t.op == "R");
    mcu.feat_wr   <= (t.op == "F");
    mcu.feat_data <= t.data;
    mcu.cmd_rd    <= (t.op == "M");
    mcu.cmd_addr  <= t.addr[8:0];
    chk_valid     <= 1'b0;
    @(posedge clk);
    snes.wr     <= 1'b0;
    snes.rd     <= 1'b0;
    mcu.feat_wr <= 1'b0;
    mcu.cmd_rd  <= 1'b0;
    chk_valid   <= 1'b1;
    chk_case    <= t;
  endtask

  initial begin
    bit ok;
    reset     = 1'b1;
    snes      = '0;
    mcu       = '0;
    chk_valid = 1'b0;
    chk_case  = '0;
    load_cases(ok);
    if (!ok) begin
      $display("could not read any case from sgb_bus_cases.txt");
      $display("FAIL: see errors above");
      $finish;
    end else begin
      limit = 20 * cases.size() + 50;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      foreach (cases[i]) begin
        apply_case(cases[i]);
      end
      @(posedge clk);
      chk_valid <= 1'b0;
      // Lets the checker see the last check cycle
      @(posedge clk);
      $display("%0d cases run, %0d errors", cases.size(), err_count);
      if (err_count == 0) begin
        $display("PASS: all tests");
      end else begin
        $display("FAIL: see errors above");
      end
      $finish;
    end
  end

endmodule

// ==== sgb_bus_top.sv ====
`timescale 1ns/1ps
`include "sgb_macros.svh"

module sgb_bus_top (
  input  logic                   clk,
  input  logic                   reset,
  input  sgb_pkg::snes_bus_t     snes,
  input  sgb_pkg::mcu_port_t     mcu,
  output sgb_pkg::addr_decode_t  decode,
  output logic [15:0]            buttons,
  output logic [`SGB_DATA_W-1:0] snes_rdata,
  output logic                   snes_rvalid,
  output logic [`SGB_DATA_W-1:0] mcu_rdata,
  output logic                   mcu_rvalid
);

  logic [`SGB_FEAT_W-1:0] featurebits;

  ////////////////////////////////////////////////////////////////////////////
  // Decode path
  ////////////////////////////////////////////////////////////////////////////

  // MCU sets which optional windows are live
  feature_regs feature_regs_i (
    .clk         (clk),
    .reset       (reset),
    .feat_wr     (mcu.feat_wr),
    .feat_data   (mcu.feat_data),
    .featurebits (featurebits)
  );

  // Purely combinational, same cycle as the bus
  address address_i (
    .snes        (snes),
    .featurebits (featurebits),
    .decode      (decode)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Decode consumers
  ////////////////////////////////////////////////////////////////////////////

  button_snoop button_snoop_i (
    .clk     (clk),
    .reset   (reset),
    .snes    (snes),
    .decode  (decode),
    .buttons (buttons)
  );

  // SNES port plus MCU read port
  snescmd_ram snescmd_ram_i (
    .clk         (clk),
    .reset       (reset),
    .snes        (snes),
    .decode      (decode),
    .cmd_rd      (mcu.cmd_rd),
    .cmd_addr    (mcu.cmd_addr),
    .snes_rdata  (snes_rdata),
    .snes_rvalid (snes_rvalid),
    .mcu_rdata   (mcu_rdata),
    .mcu_rvalid  (mcu_rvalid)
  );

endmodule

// ==== sgb_macros.svh ====
`ifndef SGB_MACROS_SVH
`define SGB_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////

// Full SNES A-bus address
`define SGB_ADDR_W 24
// One data byte on either bus
`define SGB_DATA_W 8
// MCU feature word
`define SGB_FEAT_W 16
// Address bits for the 512-byte snescmd buffer
`define SGB_CMD_AW 9

////////////////////////////////////////////////////////////////////////////
// Feature word bit positions
////////////////////////////////////////////////////////////////////////////

// MSU-1 register window enable
`define SGB_FEAT_MSU1 3
// $213F peripheral register enable
`define SGB_FEAT_213F 4

`endif

// ==== sgb_pkg.sv ====
`include "sgb_macros.svh"

package sgb_pkg;

  // SNES side of the cartridge edge
  typedef struct packed {
    logic [`SGB_ADDR_W-1:0] addr;
    // B-bus peripheral address
    logic [7:0]             pa;
    logic [`SGB_DATA_W-1:0] data;
    // Single-cycle strobes, already synchronized
    logic                   rd;
    logic                   wr;
    logic                   romsel;
  } snes_bus_t;

  // Everything the decoder works out for one address
  typedef struct packed {
    logic [`SGB_ADDR_W-1:0] rom_addr;
    logic                   rom_hit;
    logic                   is_rom;
    logic                   msu_enable;
    logic                   sgb_enable;
    logic                   r213f_enable;
    logic                   r2100_hit;
    logic                   snescmd_enable;
    logic                   button_enable;
    // Low byte at 0, high byte at 1
    logic                   button_addr;
  } addr_decode_t;

  // MCU strobes and operands
  typedef struct packed {
    logic                   feat_wr;
    logic [`SGB_FEAT_W-1:0] feat_data;
    logic                   cmd_rd;
    logic [`SGB_CMD_AW-1:0] cmd_addr;
    // Reserved, held at zero
    logic [8:0]             spare;
  } mcu_port_t;

endpackage

// ==== snescmd_ram.sv ====
`timescale 1ns/1ps
`include "sgb_macros.svh"

module snescmd_ram (
  input  logic                   clk,
  input  logic                   reset,
  input  sgb_pkg::snes_bus_t     snes,
  input  sgb_pkg::addr_decode_t  decode,
  input  logic                   cmd_rd,
  input  logic [`SGB_CMD_AW-1:0] cmd_addr,
  output logic [`SGB_DATA_W-1:0] snes_rdata,
  output logic                   snes_rvalid,
  output logic [`SGB_DATA_W-1:0] mcu_rdata,
  output logic                   mcu_rvalid
);

  logic [`SGB_DATA_W-1:0] mem [0:(1 << `SGB_CMD_AW)-1];
  logic                   snes_wr;
  logic                   snes_rd;

  // Window offset comes from the low address bits
  assign snes_wr = snes.wr & decode.snescmd_enable;
  assign snes_rd = snes.rd & decode.snescmd_enable;

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (snes_wr) begin
      mem[snes.addr[`SGB_CMD_AW-1:0]] <= snes.data;
    end
  end

  // Registered read data, one cycle latency on both sides
  always_ff @(posedge clk) begin
    if (snes_rd) begin
      snes_rdata <= mem[snes.addr[`SGB_CMD_AW-1:0]];
    end
    if (cmd_rd) begin
      mcu_rdata <= mem[cmd_addr];
    end
  end

  // Valid flags pulse for the data cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      snes_rvalid <= 1'b0;
      mcu_rvalid  <= 1'b0;
    end else begin
      snes_rvalid <= snes_rd;
      mcu_rvalid  <= cmd_rd;
    end
  end

  a_snes_rvalid: assert property (
    @(posedge clk) disable iff (reset)
    snes_rvalid |-> $past(snes.rd && decode.snescmd_enable)
  ) else $error("snes_rvalid without a decoded read");

endmodule
